// File: src/intra4x4_pkg.sv
`default_nettype none

package intra4x4_pkg;

    // block geometry and sample widths
    localparam int BLK_ROWS = 4;

    typedef logic [7:0] pixel_t;

    // pixel 0 sits in the low byte
    typedef pixel_t [3:0] pix_row_t;

    // pixel minus prediction, 9-bit wrap
    typedef logic [8:0] resid_t;
    typedef resid_t [3:0] resid_row_t;

    // worst case 16 * 255 fits in 12 bits
    typedef logic [11:0] sad_t;

    typedef logic [1:0] row_idx_t;

    // dc value when no neighbor is available
    localparam pixel_t DC_NONE = 8'd128;

    typedef struct packed {
        sad_t vert;
        sad_t horiz;
        sad_t dc;
    } sad_set_t;

    // left entry r belongs to row r
    typedef struct packed {
        pix_row_t top;
        pix_row_t left;
        logic     top_valid;
        logic     left_valid;
    } nbr_t;

    typedef struct packed {
        resid_row_t resid;
        pix_row_t   base;
    } out_row_t;

    // numbering follows the H.264 intra 4x4 modes
    typedef enum logic [3:0] {
        MODE_VERT  = 4'd0,
        MODE_HORIZ = 4'd1,
        MODE_DC    = 4'd2
    } pred_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_DECIDE,
        ST_EMIT
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/intra4x4_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module intra4x4_ctrl
    import intra4x4_pkg::*;
(
    input  wire        CLK,
    input  wire        rst_0,
    input  wire        blk_strobe,
    input  wire        row_strobe,
    input  wire nbr_t  nbr_q,
    input  wire sad_set_t sads,
    output logic       nbr_load,
    output row_idx_t   load_idx,
    output row_idx_t   rd_idx,
    output logic       emit,
    output pred_mode_e mode
);

    localparam row_idx_t LAST_ROW = row_idx_t'(BLK_ROWS - 1);

    ctrl_state_e state;
    row_idx_t    row_cnt;
    pred_mode_e  best_mode;
    sad_t        best_sad;

    assign nbr_load = blk_strobe && (state == ST_IDLE);
    assign emit     = (state == ST_EMIT);

    // one counter serves both phases, it wraps to 0 after the last load
    assign load_idx = row_cnt;
    assign rd_idx   = row_cnt;

    // dc always allowed; later checks win ties, so vert beats horiz beats dc
    always_comb
    begin
        best_mode = MODE_DC;
        best_sad  = sads.dc;
        if (nbr_q.left_valid && (sads.horiz <= best_sad))
        begin
            best_mode = MODE_HORIZ;
            best_sad  = sads.horiz;
        end
        if (nbr_q.top_valid && (sads.vert <= best_sad))
        begin
            best_mode = MODE_VERT;
            best_sad  = sads.vert;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rst_0)
        begin
            state   <= ST_IDLE;
            row_cnt <= '0;
            mode    <= MODE_VERT;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (blk_strobe)
                    begin
                        state   <= ST_LOAD;
                        row_cnt <= '0;
                    end
                end
                ST_LOAD:
                begin
                    if (row_strobe)
                    begin
                        row_cnt <= row_cnt + 2'd1;
                        if (row_cnt == LAST_ROW)
                            state <= ST_DECIDE;
                    end
                end
                // sads are final here
                ST_DECIDE:
                begin
                    mode  <= best_mode;
                    state <= ST_EMIT;
                end
                ST_EMIT:
                begin
                    row_cnt <= row_cnt + 2'd1;
                    if (row_cnt == LAST_ROW)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // sender waits for the previous block's mode strobe
    a_blk_in_idle: assert property (@(posedge CLK) disable iff (rst_0)
        blk_strobe |-> state == ST_IDLE);

    a_row_in_load: assert property (@(posedge CLK) disable iff (rst_0)
        row_strobe |-> state inside {ST_IDLE, ST_LOAD});

endmodule

`default_nettype wire

// File: src/intra4x4_dc_pred.sv
`timescale 1ns/1ps
`default_nettype none

module intra4x4_dc_pred
    import intra4x4_pkg::*;
(
    input  wire       CLK,
    input  wire       rst_0,
    input  wire       nbr_load,
    input  wire nbr_t nbr,
    output nbr_t      nbr_q,
    output pixel_t    dc_val
);

    logic [9:0]  sum_top;
    logic [9:0]  sum_left;
    logic [10:0] dc_sum;
    pixel_t      dc_next;

    // sums taken from the incoming neighbors so dc is ready with nbr_q
    always_comb
    begin
        sum_top  = '0;
        sum_left = '0;
        foreach (nbr.top[i])
        begin
            sum_top  = sum_top + 10'(nbr.top[i]);
            sum_left = sum_left + 10'(nbr.left[i]);
        end
    end

    always_comb
    begin
        dc_sum  = '0;
        dc_next = DC_NONE;
        case ({nbr.top_valid, nbr.left_valid})
            2'b11: dc_sum = {1'b0, sum_top} + {1'b0, sum_left} + 11'd4;
            2'b10: dc_sum = {sum_top, 1'b0} + 11'd4;
            2'b01: dc_sum = {sum_left, 1'b0} + 11'd4;
            default: dc_sum = '0;
        endcase
        // neither side available keeps the mid-grey value
        if (nbr.top_valid || nbr.left_valid)
            dc_next = dc_sum[10:3];
    end

    // valid flags must read low until the first block
    always_ff @(posedge CLK)
    begin
        if (rst_0)
            nbr_q <= '0;
        else if (nbr_load)
            nbr_q <= nbr;
    end

    always_ff @(posedge CLK)
    begin
        if (nbr_load)
            dc_val <= dc_next;
    end

endmodule

`default_nettype wire

// File: src/intra4x4_block_buf.sv
`timescale 1ns/1ps
`default_nettype none

module intra4x4_block_buf
    import intra4x4_pkg::*;
(
    input  wire           CLK,
    input  wire           row_strobe,
    input  wire row_idx_t load_idx,
    input  wire pix_row_t row,
    input  wire row_idx_t rd_idx,
    output pix_row_t      rd_row
);

    // one entry per block row
    pix_row_t mem [BLK_ROWS];

    always_ff @(posedge CLK)
    begin
        if (row_strobe)
            mem[load_idx] <= row;
    end

    // async read, residual registers the result
    assign rd_row = mem[rd_idx];

endmodule

`default_nettype wire

// File: src/intra4x4_sad.sv
`timescale 1ns/1ps
`default_nettype none

module intra4x4_sad
    import intra4x4_pkg::*;
(
    input  wire           CLK,
    input  wire           rst_0,
    input  wire           blk_strobe,
    input  wire           row_strobe,
    input  wire row_idx_t load_idx,
    input  wire pix_row_t row,
    input  wire nbr_t     nbr_q,
    input  wire pixel_t   dc_val,
    output sad_set_t      sads
);

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    // four differences per row, at most 4 * 255
    function automatic logic [9:0] row_sad(input pix_row_t cur, input pix_row_t pred);
        logic [9:0] acc;
        acc = '0;
        foreach (cur[i])
            acc = acc + 10'(abs_diff(cur[i], pred[i]));
        return acc;
    endfunction

    pix_row_t   horiz_pred;
    pix_row_t   dc_pred;
    logic [9:0] vert_row;
    logic [9:0] horiz_row;
    logic [9:0] dc_row;

    assign horiz_pred = {4{nbr_q.left[load_idx]}};
    assign dc_pred    = {4{dc_val}};

    assign vert_row  = row_sad(row, nbr_q.top);
    assign horiz_row = row_sad(row, horiz_pred);
    assign dc_row    = row_sad(row, dc_pred);

    always_ff @(posedge CLK)
    begin
        if (rst_0 || blk_strobe)
            sads <= '0;
        else if (row_strobe)
        begin
            sads.vert  <= sads.vert + 12'(vert_row);
            sads.horiz <= sads.horiz + 12'(horiz_row);
            sads.dc    <= sads.dc + 12'(dc_row);
        end
    end

    // accumulators only grow within a block
    a_no_wrap: assert property (@(posedge CLK) disable iff (rst_0)
        row_strobe && !blk_strobe |=> (sads.vert >= $past(sads.vert))
            && (sads.horiz >= $past(sads.horiz)) && (sads.dc >= $past(sads.dc)));

endmodule

`default_nettype wire

// File: src/intra4x4_residual.sv
`timescale 1ns/1ps
`default_nettype none

module intra4x4_residual
    import intra4x4_pkg::*;
(
    input  wire             CLK,
    input  wire             rst_0,
    input  wire             emit,
    input  wire row_idx_t   rd_idx,
    input  wire pix_row_t   rd_row,
    input  wire pred_mode_e mode,
    input  wire nbr_t       nbr_q,
    input  wire pixel_t     dc_val,
    output logic            out_strobe,
    output out_row_t        out_row,
    output logic            mode_strobe
);

    pix_row_t   base;
    resid_row_t resid;

    // prediction row for the chosen mode
    always_comb
    begin
        case (mode)
            MODE_VERT:  base = nbr_q.top;
            MODE_HORIZ: base = {4{nbr_q.left[rd_idx]}};
            default:    base = {4{dc_val}};
        endcase
    end

    // 9-bit subtract, sign comes out of the wrap
    always_comb
    begin
        foreach (resid[i])
            resid[i] = {1'b0, rd_row[i]} - {1'b0, base[i]};
    end

    always_ff @(posedge CLK)
    begin
        if (emit)
        begin
            out_row.resid <= resid;
            out_row.base  <= base;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rst_0)
        begin
            out_strobe  <= 1'b0;
            mode_strobe <= 1'b0;
        end
        else
        begin
            out_strobe  <= emit;
            // mode goes out with row 0
            mode_strobe <= emit && (rd_idx == '0);
        end
    end

    a_mode_legal: assert property (@(posedge CLK) disable iff (rst_0)
        emit |-> mode inside {MODE_VERT, MODE_HORIZ, MODE_DC});

endmodule

`default_nettype wire

// File: src/intra4x4_top.sv
`timescale 1ns/1ps
`default_nettype none

module intra4x4_top
    import intra4x4_pkg::*;
(
    input  wire           CLK,
    input  wire           rst_0,
    input  wire           blk_strobe,
    input  wire nbr_t     nbr,
    input  wire           row_strobe,
    input  wire pix_row_t row,
    output logic          out_strobe,
    output out_row_t      out_row,
    output logic          mode_strobe,
    output pred_mode_e    mode
);

    logic     nbr_load;
    row_idx_t load_idx;
    row_idx_t rd_idx;
    logic     emit;
    nbr_t     nbr_q;
    pixel_t   dc_val;
    sad_set_t sads;
    pix_row_t rd_row;

    intra4x4_ctrl u_ctrl (
        .CLK        (CLK),
        .rst_0      (rst_0),
        .blk_strobe (blk_strobe),
        .row_strobe (row_strobe),
        .nbr_q      (nbr_q),
        .sads       (sads),
        .nbr_load   (nbr_load),
        .load_idx   (load_idx),
        .rd_idx     (rd_idx),
        .emit       (emit),
        .mode       (mode)
    );

    intra4x4_dc_pred u_dc_pred (
        .CLK      (CLK),
        .rst_0    (rst_0),
        .nbr_load (nbr_load),
        .nbr      (nbr),
        .nbr_q    (nbr_q),
        .dc_val   (dc_val)
    );

    intra4x4_block_buf u_block_buf (
        .CLK        (CLK),
        .row_strobe (row_strobe),
        .load_idx   (load_idx),
        .row        (row),
        .rd_idx     (rd_idx),
        .rd_row     (rd_row)
    );

    intra4x4_sad u_sad (
        .CLK        (CLK),
        .rst_0      (rst_0),
        .blk_strobe (blk_strobe),
        .row_strobe (row_strobe),
        .load_idx   (load_idx),
        .row        (row),
        .nbr_q      (nbr_q),
        .dc_val     (dc_val),
        .sads       (sads)
    );

    intra4x4_residual u_residual (
        .CLK         (CLK),
        .rst_0       (rst_0),
        .emit        (emit),
        .rd_idx      (rd_idx),
        .rd_row      (rd_row),
        .mode        (mode),
        .nbr_q       (nbr_q),
        .dc_val      (dc_val),
        .out_strobe  (out_strobe),
        .out_row     (out_row),
        .mode_strobe (mode_strobe)
    );

endmodule

`default_nettype wire

// File: bench/intra4x4_tb_tasks.svh
`ifndef INTRA4X4_TB_TASKS_SVH
`define INTRA4X4_TB_TASKS_SVH

function automatic int distance(input int a, input int b);
    return (a > b) ? a - b : b - a;
endfunction

// reference model, straight from the dc, availability and tie rules
task automatic predict();
    int sum_t;
    int sum_l;
    int dc;
    int sv;
    int sh;
    int sd;
    int r;
    int c;
    pix_row_t base;
    sum_t = 0;
    sum_l = 0;
    for (c = 0; c < 4; c++)
    begin
        sum_t += blk_nbr.top[c];
        sum_l += blk_nbr.left[c];
    end
    if (blk_nbr.top_valid && blk_nbr.left_valid)
        dc = (sum_t + sum_l + 4) >> 3;
    else if (blk_nbr.top_valid)
        dc = (2 * sum_t + 4) >> 3;
    else if (blk_nbr.left_valid)
        dc = (2 * sum_l + 4) >> 3;
    else
        dc = DC_NONE;
    sv = 0;
    sh = 0;
    sd = 0;
    for (r = 0; r < BLK_ROWS; r++)
        for (c = 0; c < 4; c++)
        begin
            sv += distance(blk_rows[r][c], blk_nbr.top[c]);
            sh += distance(blk_rows[r][c], blk_nbr.left[r]);
            sd += distance(blk_rows[r][c], dc);
        end
    // unavailable horizontal can never win
    if (!blk_nbr.left_valid)
        sh = 1 << 20;
    if (blk_nbr.top_valid && sv <= sh && sv <= sd)
        exp_mode = MODE_VERT;
    else if (blk_nbr.left_valid && sh <= sd)
        exp_mode = MODE_HORIZ;
    else
        exp_mode = MODE_DC;
    for (r = 0; r < BLK_ROWS; r++)
    begin
        case (exp_mode)
            MODE_VERT:  base = blk_nbr.top;
            MODE_HORIZ: base = {4{blk_nbr.left[r]}};
            default:    base = {4{pixel_t'(dc)}};
        endcase
        exp_rows[r].base = base;
        for (c = 0; c < 4; c++)
            exp_rows[r].resid[c] = resid_t'(int'(blk_rows[r][c]) - int'(base[c]));
    end
endtask

task automatic set_block(input pix_row_t top, input pix_row_t left, input logic tv,
                         input logic lv, input pix_row_t fill);
    blk_nbr.top        = top;
    blk_nbr.left       = left;
    blk_nbr.top_valid  = tv;
    blk_nbr.left_valid = lv;
    foreach (blk_rows[r])
        blk_rows[r] = fill;
endtask

// gap < 0 picks a random gap of 0 to 2 cycles before each row
task automatic run_block(input int gap);
    int r;
    int g;
    int wait_cnt;
    predict();
    got_mode = pred_mode_e'(4'hF);
    got_lat  = -1;
    @(negedge CLK);
    blk_strobe = 1'b1;
    nbr        = blk_nbr;
    @(negedge CLK);
    blk_strobe = 1'b0;
    for (r = 0; r < BLK_ROWS; r++)
    begin
        g = (gap < 0) ? $unsigned($random(seed)) % 3 : gap;
        if (r > 0)
            repeat (g) @(negedge CLK);
        row_strobe = 1'b1;
        row        = blk_rows[r];
        @(negedge CLK);
        row_strobe = 1'b0;
    end
    wait_cnt = 1;
    while (!out_strobe && wait_cnt <= MAX_WAIT)
    begin
        @(negedge CLK);
        wait_cnt++;
    end
    if (!out_strobe)
    begin
        $display("no out_strobe arrived within %0d cycles of the last row, at %0t",
                 MAX_WAIT, $time);
        err_count++;
        return;
    end
    got_lat  = wait_cnt;
    got_mode = mode;
    got_base = out_row.base;
    compare("mode_strobe with row 0", mode_strobe, 1'b1);
    compare("mode", mode, exp_mode);
    for (r = 0; r < BLK_ROWS; r++)
    begin
        if (r > 0)
        begin
            @(negedge CLK);
            compare($sformatf("out_strobe row %0d", r), out_strobe, 1'b1);
        end
        compare($sformatf("out_row %0d", r), out_row, exp_rows[r]);
    end
    @(negedge CLK);
    compare("out_strobe after row 3", out_strobe, 1'b0);
endtask

task automatic after_reset_quiet();
    int errs;
    errs = err_count;
    repeat (8)
    begin
        @(negedge CLK);
        compare("out_strobe idle", out_strobe, 1'b0);
        compare("mode_strobe idle", mode_strobe, 1'b0);
    end
    report_test("reset", errs);
endtask

task automatic vertical_block();
    int errs;
    errs = err_count;
    set_block(32'hE0109040, 32'h01020304, 1'b1, 1'b1, 32'hE0109040);
    run_block(0);
    compare("vertical mode", got_mode, MODE_VERT);
    compare("vertical latency", got_lat, 3);
    report_test("vertical", errs);
endtask

task automatic horizontal_block();
    int errs;
    errs = err_count;
    set_block(32'hFA03FA03, 32'hF0A05A0F, 1'b1, 1'b1, '0);
    foreach (blk_rows[r])
        blk_rows[r] = {4{blk_nbr.left[r]}};
    run_block(2);
    compare("horizontal mode", got_mode, MODE_HORIZ);
    report_test("horizontal", errs);
endtask

task automatic dc_fallback_blocks();
    int errs;
    errs = err_count;
    // invalid top equal to the pixels
    set_block(32'h5A5A5A5A, 32'h5A5A5A5A, 1'b0, 1'b0, 32'h5A5A5A5A);
    run_block(1);
    compare("dc none mode", got_mode, MODE_DC);
    compare("dc none base", got_base, {4{8'd128}});
    // top 10,30,50,70 gives (2*160+4)>>3 = 40
    set_block(32'h46321E0A, 32'h11223344, 1'b1, 1'b0, 32'h28282828);
    run_block(0);
    compare("dc top mode", got_mode, MODE_DC);
    compare("dc top base", got_base, {4{8'd40}});
    // left 200,220,240,250 gives (2*910+4)>>3 = 228
    set_block(32'hE4E4E4E4, 32'hFAF0DCC8, 1'b0, 1'b1, 32'hE4E4E4E4);
    run_block(0);
    compare("dc left mode", got_mode, MODE_DC);
    compare("dc left base", got_base, {4{8'd228}});
    report_test("dc", errs);
endtask

task automatic tie_order_block();
    int errs;
    errs = err_count;
    set_block(32'h4D4D4D4D, 32'h4D4D4D4D, 1'b1, 1'b1, 32'h4D4D4D4D);
    run_block(0);
    compare("tie mode", got_mode, MODE_VERT);
    report_test("tie", errs);
endtask

task automatic random_blocks();
    int errs;
    int b;
    int v;
    errs = err_count;
    for (b = 0; b < 10; b++)
    begin
        v = $random(seed);
        set_block(pix_row_t'($random(seed)), pix_row_t'($random(seed)), v[0], v[1], '0);
        foreach (blk_rows[r])
            blk_rows[r] = pix_row_t'($random(seed));
        run_block(-1);
    end
    report_test("random", errs);
endtask

`endif

// File: bench/intra4x4_tb.sv
`timescale 1ns/1ps
`default_nettype none

module intra4x4_tb
    import intra4x4_pkg::*;
();

    localparam int  CLK_PERIOD = 40;
    localparam int  NUM_BLOCKS = 16;
    localparam int  MAX_WAIT   = 10;
    localparam time TIMEOUT    = (NUM_BLOCKS * 20 + 100) * CLK_PERIOD;

    logic       CLK;
    logic       rst_0;
    logic       blk_strobe;
    nbr_t       nbr;
    logic       row_strobe;
    pix_row_t   row;
    logic       out_strobe;
    out_row_t   out_row;
    logic       mode_strobe;
    pred_mode_e mode;

    int seed = 93232;
    int err_count = 0;
    int check_count = 0;
    int test_count = 0;
    int test_fail = 0;

    // current block and what the model expects from it
    nbr_t       blk_nbr;
    pix_row_t   blk_rows [BLK_ROWS];
    out_row_t   exp_rows [BLK_ROWS];
    pred_mode_e exp_mode;
    pred_mode_e got_mode;
    pix_row_t   got_base;
    int         got_lat;

    intra4x4_top DUT (
        .CLK         (CLK),
        .rst_0       (rst_0),
        .blk_strobe  (blk_strobe),
        .nbr         (nbr),
        .row_strobe  (row_strobe),
        .row         (row),
        .out_strobe  (out_strobe),
        .out_row     (out_row),
        .mode_strobe (mode_strobe),
        .mode        (mode)
    );

    task automatic compare(input string what, input logic [67:0] got, input logic [67:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("FAIL t=%0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before)
            $display("test %-10s ok", name);
        else
        begin
            test_fail++;
            $display("test %-10s %0d errors", name, err_count - errs_before);
        end
    endtask

    `include "intra4x4_tb_tasks.svh"

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial
    begin
        #(TIMEOUT);
        $display("watchdog expired before the tests completed");
        $display("sim failed");
        $finish;
    end

    initial
    begin
        rst_0      = 1'b1;
        blk_strobe = 1'b0;
        row_strobe = 1'b0;
        nbr        = '0;
        row        = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        rst_0 = 1'b0;
        after_reset_quiet();
        vertical_block();
        horizontal_block();
        dc_fallback_blocks();
        tie_order_block();
        random_blocks();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, test_fail, check_count, err_count);
        if (err_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+bench
src/intra4x4_pkg.sv
src/intra4x4_ctrl.sv
src/intra4x4_dc_pred.sv
src/intra4x4_block_buf.sv
src/intra4x4_sad.sv
src/intra4x4_residual.sv
src/intra4x4_top.sv
bench/intra4x4_tb.sv
